//--- common/mac_pkg.sv
`default_nettype none

package mac_pkg;

        // bit 0 picks the high word, bit 1 picks signed
        typedef enum logic [1:0]
        {
                UMLALL = 2'd0,
                UMLALH = 2'd1,
                SMLALL = 2'd2,
                SMLALH = 2'd3
        } mac_op_t;

        typedef enum logic [2:0]
        {
                IDLE = 3'd0,
                S1   = 3'd1,    // lo x lo
                S2   = 3'd2,    // hi x hi
                S3   = 3'd3,    // rm hi x rs lo
                S4   = 3'd4,    // rs hi x rm lo
                S5   = 3'd5,    // add {rh, rn}
                S6   = 3'd6     // result out
        } mac_state_t;

        // register block to multiplier
        typedef struct packed
        {
                logic           go;
                mac_op_t        op;
                logic [31:0]    rm;
                logic [31:0]    rs;
                logic [31:0]    rn;
                logic [31:0]    rh;
        } mac_req_t;

        // multiplier to register block
        typedef struct packed
        {
                logic           busy;
                logic           done;     // one cycle, in S6
                logic [31:0]    result;
        } mac_rsp_t;

endpackage

`default_nettype wire

//--- common/bus_pkg.sv
`default_nettype none

package bus_pkg;

        typedef struct packed
        {
                logic           cyc;
                logic           stb;
                logic           we;
                logic [4:0]     adr;      // byte address
                logic [31:0]    dat;
        } wb_req_t;

        typedef struct packed
        {
                logic           ack;
                logic [31:0]    dat;
        } wb_rsp_t;

        localparam logic [4:0] REG_RM     = 5'h00;
        localparam logic [4:0] REG_RS     = 5'h04;
        localparam logic [4:0] REG_RN     = 5'h08;
        localparam logic [4:0] REG_RH     = 5'h0C;
        localparam logic [4:0] REG_CTRL   = 5'h10;
        localparam logic [4:0] REG_STATUS = 5'h14;
        localparam logic [4:0] REG_RESULT = 5'h18;

        // control and status bit positions
        localparam int CTRL_START = 2;
        localparam int CTRL_ABORT = 3;
        localparam int STAT_BUSY  = 0;
        localparam int STAT_DONE  = 1;

endpackage

`default_nettype wire

//--- multiply/mac_multiply.sv
`timescale 1ns/1ps
`default_nettype none

module mac_multiply
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_hold,
        input  logic                    i_abort,
        input  mac_pkg::mac_req_t       i_req,
        output mac_pkg::mac_rsp_t       o_rsp
);

        mac_pkg::mac_state_t    state_ff;
        mac_pkg::mac_state_t    state_nxt;
        mac_pkg::mac_op_t       op_ff;
        mac_pkg::mac_op_t       op_nxt;
        logic signed [63:0]     acc_ff;
        logic signed [63:0]     acc_nxt;
        logic                   pend_ff;
        logic                   start;
        logic                   sign;
        logic                   higher;
        logic signed [16:0]     rm_hi;
        logic signed [16:0]     rs_hi;
        logic signed [16:0]     rm_lo;
        logic signed [16:0]     rs_lo;
        logic signed [16:0]     in1;
        logic signed [16:0]     in2;
        logic signed [33:0]     prod;
        logic signed [63:0]     prod_ext;
        logic                   busy;
        logic                   done;
        logic [31:0]            result;

        assign start  = i_req.go | pend_ff;     // go seen during hold waits
        assign sign   = op_ff[1];
        assign higher = op_ff[0];

        assign rm_hi = sign ? {i_req.rm[31], i_req.rm[31:16]} : {1'b0, i_req.rm[31:16]};
        assign rs_hi = sign ? {i_req.rs[31], i_req.rs[31:16]} : {1'b0, i_req.rs[31:16]};
        assign rm_lo = {1'b0, i_req.rm[15:0]};
        assign rs_lo = {1'b0, i_req.rs[15:0]};

        always_comb
        begin
                in1 = '0;
                in2 = '0;
                case (state_ff)
                mac_pkg::S1:
                begin
                        in1 = rm_lo;
                        in2 = rs_lo;
                end
                mac_pkg::S2:
                begin
                        in1 = rm_hi;
                        in2 = rs_hi;
                end
                mac_pkg::S3:
                begin
                        in1 = rm_hi;
                        in2 = rs_lo;
                end
                mac_pkg::S4:
                begin
                        in1 = rs_hi;
                        in2 = rm_lo;
                end
                default:
                begin
                        in1 = '0;
                        in2 = '0;
                end
                endcase
        end

        // the one shared 17x17 product
        assign prod     = in1 * in2;
        assign prod_ext = 64'(prod);    // sign extends

        always_comb
        begin
                state_nxt = state_ff;
                op_nxt    = op_ff;
                acc_nxt   = acc_ff;
                busy      = 1'b1;
                done      = 1'b0;
                result    = '0;
                case (state_ff)
                mac_pkg::IDLE:
                begin
                        busy    = start;
                        acc_nxt = '0;
                        if (start)
                        begin
                                state_nxt = mac_pkg::S1;
                                op_nxt    = i_req.op;
                        end
                end
                mac_pkg::S1:
                begin
                        acc_nxt   = acc_ff + prod_ext;
                        state_nxt = mac_pkg::S2;
                end
                mac_pkg::S2:
                begin
                        acc_nxt   = acc_ff + (prod_ext <<< 32);
                        state_nxt = mac_pkg::S3;
                end
                mac_pkg::S3:
                begin
                        acc_nxt   = acc_ff + (prod_ext <<< 16);
                        state_nxt = mac_pkg::S4;
                end
                mac_pkg::S4:
                begin
                        acc_nxt   = acc_ff + (prod_ext <<< 16);
                        state_nxt = mac_pkg::S5;
                end
                mac_pkg::S5:
                begin
                        acc_nxt   = acc_ff + $signed({i_req.rh, i_req.rn});
                        state_nxt = mac_pkg::S6;
                end
                mac_pkg::S6:
                begin
                        busy      = i_hold;                     // stays up while held
                        done      = !i_hold && !i_abort;        // pulse only on the leaving edge
                        result    = higher ? acc_ff[63:32] : acc_ff[31:0];
                        state_nxt = mac_pkg::IDLE;
                end
                default:
                begin
                        state_nxt = mac_pkg::IDLE;
                end
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_ff <= mac_pkg::IDLE;
                        op_ff    <= mac_pkg::UMLALL;
                        acc_ff   <= '0;
                        pend_ff  <= 1'b0;
                end
                else if (i_abort)       // beats hold
                begin
                        state_ff <= mac_pkg::IDLE;
                        acc_ff   <= '0;
                        pend_ff  <= 1'b0;
                end
                else if (i_hold)
                begin
                        pend_ff <= start && (state_ff == mac_pkg::IDLE);
                end
                else
                begin
                        state_ff <= state_nxt;
                        op_ff    <= op_nxt;
                        acc_ff   <= acc_nxt;
                        pend_ff  <= 1'b0;
                end
        end

        assign o_rsp = '{busy: busy, done: done, result: result};

        a_done_in_s6: assert property (@(posedge i_clk) disable iff (i_reset)
                o_rsp.done |-> state_ff == mac_pkg::S6)
                else $error("done raised outside S6");

        a_go_not_busy: assert property (@(posedge i_clk) disable iff (i_reset)
                i_req.go |-> (state_ff == mac_pkg::IDLE && !pend_ff))
                else $error("go arrived while the multiplier was busy");

        a_leave_idle: assert property (@(posedge i_clk) disable iff (i_reset)
                ($past(state_ff) == mac_pkg::IDLE && state_ff != mac_pkg::IDLE)
                |-> $past(start))
                else $error("sequence left IDLE without go");

endmodule

`default_nettype wire

//--- logic/mac_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mac_regs
#(
        parameter logic [31:0] RESET_RESULT = 32'h0
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  bus_pkg::wb_req_t        i_wb,
        output bus_pkg::wb_rsp_t        o_wb,
        output mac_pkg::mac_req_t       o_req,
        output logic                    o_abort,
        input  mac_pkg::mac_rsp_t       i_rsp
);

        logic                   ack_ff;
        logic [31:0]            rdata_ff;
        logic [31:0]            rdata;
        logic [31:0]            status;
        logic [31:0]            result_ff;
        logic                   done_ff;
        logic                   abort_ff;
        logic                   wb_hit;
        logic                   wb_wr;
        logic                   wb_rd;
        logic                   mac_busy;
        logic                   ctrl_wr;
        logic                   start_cmd;
        logic                   abort_cmd;
        mac_pkg::mac_req_t      req_ff;

        // no hit in the ack cycle, so each transfer is two cycles
        assign wb_hit = i_wb.cyc && i_wb.stb && !ack_ff;
        assign wb_wr  = wb_hit && i_wb.we;
        assign wb_rd  = wb_hit && !i_wb.we;

        // S6 counts as busy so that status and the start guard stay consistent
        assign mac_busy = i_rsp.busy || i_rsp.done;

        assign ctrl_wr   = wb_wr && (i_wb.adr == bus_pkg::REG_CTRL);
        assign abort_cmd = ctrl_wr && i_wb.dat[bus_pkg::CTRL_ABORT];
        assign start_cmd = ctrl_wr && i_wb.dat[bus_pkg::CTRL_START] && !abort_cmd && !mac_busy;

        always_comb
        begin
                status                     = '0;
                status[bus_pkg::STAT_BUSY] = mac_busy;
                status[bus_pkg::STAT_DONE] = done_ff;
        end

        always_comb
        begin
                case (i_wb.adr)
                bus_pkg::REG_RM:        rdata = req_ff.rm;
                bus_pkg::REG_RS:        rdata = req_ff.rs;
                bus_pkg::REG_RN:        rdata = req_ff.rn;
                bus_pkg::REG_RH:        rdata = req_ff.rh;
                bus_pkg::REG_STATUS:    rdata = status;
                bus_pkg::REG_RESULT:    rdata = result_ff;
                default:                rdata = '0;     // ctrl and holes
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        ack_ff    <= 1'b0;
                        req_ff    <= '0;
                        abort_ff  <= 1'b0;
                        done_ff   <= 1'b0;
                        result_ff <= RESET_RESULT;
                end
                else
                begin
                        ack_ff   <= wb_hit;
                        req_ff.go <= start_cmd;
                        abort_ff <= abort_cmd;

                        if (wb_wr && !mac_busy)         // operands frozen while busy
                        begin
                                case (i_wb.adr)
                                bus_pkg::REG_RM:        req_ff.rm <= i_wb.dat;
                                bus_pkg::REG_RS:        req_ff.rs <= i_wb.dat;
                                bus_pkg::REG_RN:        req_ff.rn <= i_wb.dat;
                                bus_pkg::REG_RH:        req_ff.rh <= i_wb.dat;
                                default:                ;
                                endcase
                        end

                        if (start_cmd)
                                req_ff.op <= mac_pkg::mac_op_t'(i_wb.dat[1:0]);

                        if (i_rsp.done)
                                result_ff <= i_rsp.result;

                        if (i_rsp.done)
                                done_ff <= 1'b1;
                        else if (start_cmd || (wb_rd && i_wb.adr == bus_pkg::REG_STATUS))
                                done_ff <= 1'b0;        // cleared on read
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (wb_hit)
                        rdata_ff <= rdata;
        end

        assign o_wb    = '{ack: ack_ff, dat: rdata_ff};
        assign o_req   = req_ff;
        assign o_abort = abort_ff;

        a_ack_single: assert property (@(posedge i_clk) disable iff (i_reset)
                ack_ff |=> !ack_ff)
                else $error("ack held for two cycles");

        a_go_abort: assert property (@(posedge i_clk) disable iff (i_reset)
                !(req_ff.go && abort_ff))
                else $error("go and abort issued together");

endmodule

`default_nettype wire

//--- logic/mac_top.sv
`timescale 1ns/1ps
`default_nettype none

module mac_top
#(
        parameter logic [31:0] RESET_RESULT = 32'h0
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_hold,
        input  bus_pkg::wb_req_t        i_wb,
        output bus_pkg::wb_rsp_t        o_wb
);

        mac_pkg::mac_req_t      mac_req;
        mac_pkg::mac_rsp_t      mac_rsp;
        logic                   mac_abort;

        mac_regs
        #(
                .RESET_RESULT   (RESET_RESULT)
        )
        u_regs
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_wb           (i_wb),
                .o_wb           (o_wb),
                .o_req          (mac_req),
                .o_abort        (mac_abort),
                .i_rsp          (mac_rsp)
        );

        mac_multiply u_multiply
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_hold         (i_hold),       // acts as the data stall
                .i_abort        (mac_abort),
                .i_req          (mac_req),
                .o_rsp          (mac_rsp)
        );

endmodule

`default_nettype wire

//--- dv/tb_mac.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac;

        localparam logic [31:0] RESET_VALUE = 32'hC0DE_0042;
        localparam int          N_RANDOM    = 40;
        localparam int          N_HOLD      = 4;
        localparam int          N_OPS       = 6 + N_RANDOM + 1 + N_HOLD + 2;
        localparam int          WATCHDOG_NS = N_OPS * 40 * 8 + 2000;
        localparam int          ACK_LIMIT   = 8;

        logic                   clk;
        logic                   reset;
        logic                   hold;
        bus_pkg::wb_req_t       wb_req;
        bus_pkg::wb_rsp_t       wb_rsp;
        logic                   chk_en;         // next read is checked against exp_val
        logic [31:0]            exp_val;
        logic [31:0]            last_result;
        logic [31:0]            rng_state;
        int                     mismatch_count;
        int                     fail_count;

        mac_top
        #(
                .RESET_RESULT   (RESET_VALUE)
        )
        DUT
        (
                .i_clk          (clk),
                .i_reset        (reset),
                .i_hold         (hold),
                .i_wb           (wb_req),
                .o_wb           (wb_rsp)
        );

        initial
        begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        initial
        begin
                #(WATCHDOG_NS);
                $display("watchdog expired, the run did not complete in time");
                $display("Simulation finished: FAIL");
                $finish;
        end

        function automatic logic [31:0] xorshift(input logic [31:0] s);
                logic [31:0] x;
                x = s ^ (s << 13);
                x = x ^ (x >> 17);
                return x ^ (x << 5);
        endfunction

        function automatic logic [31:0] next_rand();
                rng_state = xorshift(rng_state);
                return rng_state;
        endfunction

        // rm * rs + {rh, rn}, low or high word
        function automatic logic [31:0] expect_mac(input logic [1:0] op, input logic [31:0] rm,
                input logic [31:0] rs, input logic [31:0] rn, input logic [31:0] rh);
                logic [63:0] prod;
                logic [63:0] sum;
                if (op[1])
                        prod = {{32{rm[31]}}, rm} * {{32{rs[31]}}, rs};  // two's complement wrap
                else
                        prod = {32'h0, rm} * {32'h0, rs};
                sum = prod + {rh, rn};
                return op[0] ? sum[63:32] : sum[31:0];
        endfunction

        function automatic string reg_name(input logic [4:0] adr);
                case (adr)
                bus_pkg::REG_RM:        return "RM";
                bus_pkg::REG_RS:        return "RS";
                bus_pkg::REG_RN:        return "RN";
                bus_pkg::REG_RH:        return "RH";
                bus_pkg::REG_CTRL:      return "CTRL";
                bus_pkg::REG_STATUS:    return "STATUS";
                bus_pkg::REG_RESULT:    return "RESULT";
                default:                return "UNMAPPED";
                endcase
        endfunction

        task automatic wait_cycles(input int n);
                repeat (n)
                begin
                        @(posedge clk);
                        #1;
                end
        endtask

        task automatic bus_xfer(input logic we, input logic [4:0] adr, input logic [31:0] wdat,
                output logic [31:0] rdat);
                int waited;
                waited     = 0;
                wb_req.cyc = 1'b1;
                wb_req.stb = 1'b1;
                wb_req.we  = we;
                wb_req.adr = adr;
                wb_req.dat = wdat;
                do
                begin
                        @(posedge clk);
                        #1;
                        waited++;
                end
                while (!wb_rsp.ack && waited < ACK_LIMIT);
                if (!wb_rsp.ack)
                begin
                        fail_count++;
                        $display("no ack for %s access at %0t", reg_name(adr), $time);
                end
                rdat       = wb_rsp.dat;
                wb_req.cyc = 1'b0;
                wb_req.stb = 1'b0;
                wait_cycles(1);         // adr and we stay put through the ack edge
        endtask

        task automatic wb_write(input logic [4:0] adr, input logic [31:0] dat);
                logic [31:0] unused;
                bus_xfer(1'b1, adr, dat, unused);
        endtask

        task automatic wb_read(input logic [4:0] adr, output logic [31:0] dat);
                bus_xfer(1'b0, adr, 32'h0, dat);
        endtask

        task automatic check_read(input logic [4:0] adr, input logic [31:0] value);
                logic [31:0] d;
                exp_val = value;
                chk_en  = 1'b1;
                wb_read(adr, d);
                chk_en  = 1'b0;
        endtask

        task automatic start_op(input logic [1:0] op, input logic [31:0] rm, input logic [31:0] rs,
                input logic [31:0] rn, input logic [31:0] rh);
                wb_write(bus_pkg::REG_RM, rm);
                wb_write(bus_pkg::REG_RS, rs);
                wb_write(bus_pkg::REG_RN, rn);
                wb_write(bus_pkg::REG_RH, rh);
                wb_write(bus_pkg::REG_CTRL, {28'h0, 1'b0, 1'b1, op});
        endtask

        task automatic wait_done();
                logic [31:0]    st;
                int             polls;
                st    = '0;
                polls = 0;
                while (!st[bus_pkg::STAT_DONE] && polls < 100)
                begin
                        wb_read(bus_pkg::REG_STATUS, st);
                        polls++;
                end
                if (!st[bus_pkg::STAT_DONE])
                begin
                        fail_count++;
                        $display("operation never reported done at %0t", $time);
                end
        endtask

        task automatic run_op(input logic [1:0] op, input logic [31:0] rm, input logic [31:0] rs,
                input logic [31:0] rn, input logic [31:0] rh);
                start_op(op, rm, rs, rn, rh);
                check_read(bus_pkg::REG_STATUS, 32'h1);         // busy, done cleared by start
                wait_done();
                last_result = expect_mac(op, rm, rs, rn, rh);
                check_read(bus_pkg::REG_RESULT, last_result);
        endtask

        a_read_value: assert property (@(posedge clk) disable iff (reset)
                (chk_en && wb_rsp.ack && !wb_req.we) |-> wb_rsp.dat == exp_val)
                else
                begin
                        mismatch_count++;
                        $display("MISMATCH at %0t: o_wb.dat (%s) got %08h expected %08h", $time,
                                reg_name($sampled(wb_req.adr)), $sampled(wb_rsp.dat),
                                $sampled(exp_val));
                end

        // stb seen on three edges means ack came late
        a_ack_in_time: assert property (@(posedge clk) disable iff (reset)
                !(wb_req.stb && $past(wb_req.stb) && $past(wb_req.stb, 2)))
                else
                begin
                        fail_count++;
                        $display("ack did not arrive within two cycles of stb at %0t", $time);
                end

        a_abort_idle: assert property (@(posedge clk) disable iff (reset)
                DUT.mac_abort |=> DUT.u_multiply.state_ff == mac_pkg::IDLE)
                else
                begin
                        fail_count++;
                        $display("multiplier not back in IDLE after abort at %0t", $time);
                end

        initial
        begin
                logic [1:0]     op;
                logic [31:0]    a;
                logic [31:0]    b;
                reset          = 1'b1;
                hold           = 1'b0;
                wb_req         = '0;
                chk_en         = 1'b0;
                exp_val        = '0;
                mismatch_count = 0;
                fail_count     = 0;
                rng_state      = 32'd34;
                last_result    = RESET_VALUE;
                repeat (4) @(posedge clk);
                #1;
                reset = 1'b0;

                check_read(bus_pkg::REG_STATUS, 32'h0);
                check_read(bus_pkg::REG_RESULT, RESET_VALUE);
                check_read(bus_pkg::REG_RM, 32'h0);
                check_read(bus_pkg::REG_RS, 32'h0);
                check_read(bus_pkg::REG_RN, 32'h0);
                check_read(bus_pkg::REG_RH, 32'h0);
                check_read(bus_pkg::REG_CTRL, 32'h0);

                run_op(mac_pkg::UMLALL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'h0);
                run_op(mac_pkg::UMLALH, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'h0);
                run_op(mac_pkg::SMLALL, 32'hFFFF_FFFD, 32'hFFFF_FFF9, 32'h0, 32'h0);
                run_op(mac_pkg::SMLALH, 32'h8000_0000, 32'h8000_0000, 32'h0, 32'h0);
                run_op(mac_pkg::SMLALL, 32'h8765_4321, 32'h0001_2345, 32'h1111_0000, 32'h0);
                run_op(mac_pkg::SMLALH, 32'h0000_0005, 32'hFFFF_FFF7, 32'h0, 32'h0000_0001);

                repeat (N_RANDOM)
                begin
                        a  = next_rand();
                        op = a[1:0];
                        run_op(op, next_rand(), next_rand(), next_rand(), next_rand());
                end

                // operands and start are ignored while busy
                a = next_rand();
                b = next_rand();
                start_op(mac_pkg::SMLALH, a, b, 32'h1234_5678, 32'h9ABC_DEF0);
                wb_write(bus_pkg::REG_RM, ~a);
                wb_write(bus_pkg::REG_CTRL, 32'h4);
                wait_done();
                last_result = expect_mac(mac_pkg::SMLALH, a, b, 32'h1234_5678, 32'h9ABC_DEF0);
                check_read(bus_pkg::REG_RESULT, last_result);
                check_read(bus_pkg::REG_RM, a);

                repeat (N_HOLD)
                begin
                        a  = next_rand();
                        b  = next_rand();
                        op = a[5:4];
                        start_op(op, a, b, a ^ b, b);
                        wait_cycles(next_rand() % 6);   // up to S6
                        hold = 1'b1;
                        wait_cycles(1 + next_rand() % 16);
                        hold = 1'b0;
                        wait_done();
                        last_result = expect_mac(op, a, b, a ^ b, b);
                        check_read(bus_pkg::REG_RESULT, last_result);
                end

                start_op(mac_pkg::UMLALL, next_rand(), next_rand(), 32'h0, 32'h0);
                wb_write(bus_pkg::REG_CTRL, 32'h8);
                wait_cycles(12);
                check_read(bus_pkg::REG_STATUS, 32'h0);
                check_read(bus_pkg::REG_RESULT, last_result);

                start_op(mac_pkg::SMLALL, next_rand(), next_rand(), 32'h0, 32'h0);
                hold = 1'b1;
                wb_write(bus_pkg::REG_CTRL, 32'h8);     // abort wins over hold
                hold = 1'b0;
                wait_cycles(12);
                check_read(bus_pkg::REG_STATUS, 32'h0);
                check_read(bus_pkg::REG_RESULT, last_result);

                wait_cycles(2);
                $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
                if (mismatch_count == 0 && fail_count == 0)
                        $display("Simulation finished: PASS");
                else
                        $display("Simulation finished: FAIL");
                $finish;
        end

endmodule

`default_nettype wire

//--- sources.f
common/mac_pkg.sv
common/bus_pkg.sv
multiply/mac_multiply.sv
logic/mac_regs.sv
logic/mac_top.sv
dv/tb_mac.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mac -f sources.f -o sim_tb_mac \
        && ./obj_dir/sim_tb_mac | tee /dev/stderr \
        | grep -F "Simulation finished: PASS" > /dev/null \
        && echo "run_sim: passed" \
        || { echo "run_sim: failed"; exit 1; }
